// File: src/mlp_cmd_pkg.sv
package mlp_cmd_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [7:0] {
        CMD_WRITE_WEIGHT = 8'h01,
        CMD_WRITE_ACT    = 8'h02,
        CMD_EXECUTE      = 8'h03,
        CMD_READ_RESULT  = 8'h04,
        CMD_STATUS       = 8'h05
    } opcode_e;

    // Payload length of both write commands
    localparam int PAYLOAD_BYTES = 4;

    // Same four bytes seen as weights or as two activation rows
    typedef union packed {
        byte_t [3:0]       weight;
        logic [1:0][15:0]  act;
    } payload_u;

    typedef struct packed {
        logic        push_col0;
        logic        push_col1;
        byte_t       wf_data;
        logic        act_valid;
        logic [15:0] act_data;
        logic        start;
    } mlp_ctrl_t;

    typedef struct packed {
        logic [3:0]         state;
        logic [4:0]         cycle_cnt;
        logic signed [31:0] acc0;
    } mlp_status_t;

    // Response bytes go out LSB first
    typedef struct packed {
        logic        valid;
        logic        four_bytes;
        logic [31:0] data;
    } resp_req_t;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import mlp_cmd_pkg::*;
#(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115200
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);
    localparam int HALF_CNT     = (CLKS_PER_BIT - 1) / 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e  state;
    logic [1:0] sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0] bit_idx;
    byte_t      shift;
    logic       rx_s;

    assign rx_s    = sync[1];
    assign rx_data = shift;

    // Metastability guard on the async line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], rx};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (cnt == CNT_W'(HALF_CNT)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        // Framing error drops the byte
                        rx_valid <= rx_s;
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            shift <= {rx_s, shift[7:1]};
        end
    end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import mlp_cmd_pkg::*;
#(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115200
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx_ready,
    output logic  tx
);

    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    // Stop, data and start bits, shifted out from bit 0
    logic [9:0]       shreg;

    assign tx_ready = !busy;
    assign tx       = shreg[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            shreg   <= '1;
        end else if (!busy) begin
            if (tx_valid) begin
                shreg   <= {1'b1, tx_data, 1'b0};
                busy    <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt   <= '0;
            shreg <= {1'b1, shreg[9:1]};
            // Idle again once the stop bit has had its full time
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: src/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser
    import mlp_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  byte_t       rx_data,
    input  logic        rx_valid,
    input  mlp_status_t status,
    input  logic        loader_busy,
    input  logic        resp_busy,
    output payload_u    payload,
    output logic        load_weights,
    output logic        load_acts,
    output logic        start,
    output resp_req_t   resp
);

    typedef enum logic {P_WAIT_OP, P_COLLECT} parse_state_e;

    parse_state_e state;
    logic         is_weight;
    logic [1:0]   idx;
    logic         resp_valid;
    logic         resp_four;
    logic [31:0]  resp_data;
    logic         op_take;

    // New opcodes only when both downstream blocks are free
    assign op_take = rx_valid && state == P_WAIT_OP && !loader_busy && !resp_busy;

    assign resp = '{valid: resp_valid, four_bytes: resp_four, data: resp_data};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= P_WAIT_OP;
            is_weight    <= 1'b0;
            idx          <= '0;
            load_weights <= 1'b0;
            load_acts    <= 1'b0;
            start        <= 1'b0;
            resp_valid   <= 1'b0;
            resp_four    <= 1'b0;
        end else begin
            load_weights <= 1'b0;
            load_acts    <= 1'b0;
            start        <= 1'b0;
            resp_valid   <= 1'b0;
            if (op_take) begin
                case (opcode_e'(rx_data))
                    CMD_WRITE_WEIGHT, CMD_WRITE_ACT: begin
                        is_weight <= (opcode_e'(rx_data) == CMD_WRITE_WEIGHT);
                        idx       <= '0;
                        state     <= P_COLLECT;
                    end
                    CMD_EXECUTE:     start <= 1'b1;
                    CMD_READ_RESULT: begin
                        resp_valid <= 1'b1;
                        resp_four  <= 1'b1;
                    end
                    CMD_STATUS: begin
                        resp_valid <= 1'b1;
                        resp_four  <= 1'b0;
                    end
                    default: ;
                endcase
            end else if (rx_valid && state == P_COLLECT) begin
                idx <= idx + 1'b1;
                if (idx == 2'(PAYLOAD_BYTES - 1)) begin
                    load_weights <= is_weight;
                    load_acts    <= !is_weight;
                    state        <= P_WAIT_OP;
                end
            end
        end
    end

    // Payload and response data
    always_ff @(posedge clk) begin
        if (rx_valid && state == P_COLLECT) begin
            payload.weight[idx] <= rx_data;
        end
        if (op_take) begin
            if (opcode_e'(rx_data) == CMD_STATUS) begin
                resp_data <= {24'd0, status.state[2:0], status.cycle_cnt};
            end else begin
                resp_data <= status.acc0;
            end
        end
    end

endmodule

// File: src/mlp_loader.sv
`timescale 1ns/1ps

module mlp_loader
    import mlp_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  payload_u  payload,
    input  logic      load_weights,
    input  logic      load_acts,
    output mlp_ctrl_t ctrl_load,
    output logic      weights_ready,
    output logic      loader_busy
);

    logic       busy;
    logic       wmode;
    logic [1:0] seq;
    payload_u   held;

    // Step 0 comes straight from the load pulse, later steps from the held copy
    payload_u   cur;
    logic [1:0] step;
    logic       mode;
    logic       emit;
    logic [1:0] last_step;

    logic        push_col0;
    logic        push_col1;
    byte_t       wf_data;
    logic        act_valid;
    logic [15:0] act_data;

    assign cur       = busy ? held : payload;
    assign step      = busy ? seq : 2'd0;
    assign mode      = busy ? wmode : load_weights;
    assign emit      = busy || load_weights || load_acts;
    assign last_step = mode ? 2'd3 : 2'd1;

    assign loader_busy = busy;
    assign ctrl_load   = '{push_col0: push_col0, push_col1: push_col1, wf_data: wf_data,
                           act_valid: act_valid, act_data: act_data, start: 1'b0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy          <= 1'b0;
            wmode         <= 1'b0;
            seq           <= '0;
            push_col0     <= 1'b0;
            push_col1     <= 1'b0;
            act_valid     <= 1'b0;
            weights_ready <= 1'b0;
        end else begin
            busy      <= emit && step != last_step;
            wmode     <= mode;
            seq       <= step + 1'b1;
            // Even steps go to col0, odd steps to col1
            push_col0 <= emit && mode && !step[0];
            push_col1 <= emit && mode && step[0];
            act_valid <= emit && !mode;
            if (emit && mode && step == 2'd3) begin
                weights_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            held <= payload;
        end
        wf_data  <= cur.weight[step];
        act_data <= cur.act[step[0]];
    end

endmodule

// File: src/resp_sender.sv
`timescale 1ns/1ps

module resp_sender
    import mlp_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  resp_req_t resp,
    input  logic      tx_ready,
    output byte_t     tx_data,
    output logic      tx_valid,
    output logic      resp_busy
);

    typedef enum logic [1:0] {S_IDLE, S_OFFER, S_WAIT} send_state_e;

    send_state_e state;
    logic [1:0]  left;
    logic [31:0] buffer;

    assign tx_valid  = (state == S_OFFER);
    assign tx_data   = buffer[7:0];
    assign resp_busy = (state != S_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            left  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (resp.valid) begin
                        left  <= resp.four_bytes ? 2'd3 : 2'd0;
                        state <= S_OFFER;
                    end
                end
                S_OFFER: begin
                    // Byte taken on this edge
                    if (tx_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // Transmitter idle again after the stop bit
                    if (tx_ready) begin
                        if (left == 2'd0) begin
                            state <= S_IDLE;
                        end else begin
                            left  <= left - 1'b1;
                            state <= S_OFFER;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && resp.valid) begin
            buffer <= resp.data;
        end else if (state == S_WAIT && tx_ready) begin
            buffer <= {8'd0, buffer[31:8]};
        end
    end

endmodule

// File: src/uart_controller.sv
`timescale 1ns/1ps

module uart_controller
    import mlp_cmd_pkg::*;
#(
    parameter int CLOCK_FREQ = 100_000_000,
    parameter int BAUD_RATE  = 115200
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        uart_rx,
    output logic        uart_tx,
    output mlp_ctrl_t   mlp_ctrl,
    output logic        weights_ready,
    input  mlp_status_t status
);

    byte_t     rx_data;
    logic      rx_valid;
    payload_u  payload;
    logic      load_weights;
    logic      load_acts;
    logic      start;
    resp_req_t resp;
    logic      loader_busy;
    logic      resp_busy;
    mlp_ctrl_t ctrl_load;
    byte_t     tx_data;
    logic      tx_valid;
    logic      tx_ready;

    // Loader fields plus the parser's start pulse
    always_comb begin
        mlp_ctrl       = ctrl_load;
        mlp_ctrl.start = start;
    end

    uart_rx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
        .clk(clk), .rst(rst), .rx(uart_rx), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    cmd_parser u_parser (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid), .status(status),
        .loader_busy(loader_busy), .resp_busy(resp_busy), .payload(payload),
        .load_weights(load_weights), .load_acts(load_acts), .start(start), .resp(resp)
    );

    mlp_loader u_loader (
        .clk(clk), .rst(rst), .payload(payload), .load_weights(load_weights),
        .load_acts(load_acts), .ctrl_load(ctrl_load), .weights_ready(weights_ready),
        .loader_busy(loader_busy)
    );

    resp_sender u_sender (
        .clk(clk), .rst(rst), .resp(resp), .tx_ready(tx_ready), .tx_data(tx_data),
        .tx_valid(tx_valid), .resp_busy(resp_busy)
    );

    uart_tx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
        .clk(clk), .rst(rst), .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .tx(uart_tx)
    );

endmodule

// File: verif/uart_checker.sv
`timescale 1ns/1ps

module uart_checker
    import mlp_cmd_pkg::*;
#(
    parameter int CLKS_PER_BIT = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        uart_tx,
    input  mlp_ctrl_t   mlp_ctrl,
    input  logic        weights_ready,
    input  mlp_status_t status,
    input  byte_t       op,
    input  byte_t [3:0] payload,
    input  logic        check,
    output int          events,
    output int          expect_n,
    output int          value_errs,
    output int          event_errs
);

    logic [9:0]  pushes[$];
    logic [15:0] rows[$];
    byte_t       resp_bytes[$];
    int          starts;
    logic        ready_expect;
    logic        dec_busy;
    int          dec_cnt;
    byte_t       dec_byte;

    function automatic int resp_len(byte_t code);
        return code == CMD_READ_RESULT ? 4 : (code == CMD_STATUS ? 1 : 0);
    endfunction

    // Byte i of the response, acc0 goes out LSB first
    function automatic byte_t resp_byte(byte_t code, mlp_status_t st, int i);
        if (code == CMD_STATUS) begin
            return {st.state[2:0], st.cycle_cnt};
        end
        return st.acc0[8*i +: 8];
    endfunction

    // Col1 and col0 flags above the weight byte
    function automatic logic [9:0] weight_push(byte_t [3:0] pl, int i);
        return {i % 2 == 1, i % 2 == 0, pl[2'(i)]};
    endfunction

    function automatic logic [15:0] act_row(byte_t [3:0] pl, int r);
        return {pl[2'(2 * r + 1)], pl[2'(2 * r)]};
    endfunction

    function automatic int event_count(byte_t code);
        case (code)
            CMD_WRITE_WEIGHT: return 4;
            CMD_WRITE_ACT:    return 2;
            CMD_EXECUTE:      return 1;
            default:          return resp_len(code);
        endcase
    endfunction

    assign expect_n = event_count(op);

    task automatic count_check(string what, int got, int want);
        if (got != want) begin
            event_errs++;
            $display("Command 0x%02h produced %0d %s where %0d were expected",
                     op, got, what, want);
        end
    endtask

    task automatic value_check(string what, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            value_errs++;
            $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic compare_command();
        int n_push;
        int n_row;
        int i;
        n_push = (op == CMD_WRITE_WEIGHT) ? 4 : 0;
        n_row  = (op == CMD_WRITE_ACT) ? 2 : 0;
        count_check("pushes", pushes.size(), n_push);
        count_check("activation rows", rows.size(), n_row);
        count_check("start pulses", starts, op == CMD_EXECUTE ? 1 : 0);
        count_check("response bytes", resp_bytes.size(), resp_len(op));
        for (i = 0; i < pushes.size() && i < n_push; i++) begin
            value_check($sformatf("push %0d", i), 32'(pushes[i]),
                        32'(weight_push(payload, i)));
        end
        for (i = 0; i < rows.size() && i < n_row; i++) begin
            value_check($sformatf("row %0d", i), 32'(rows[i]), 32'(act_row(payload, i)));
        end
        for (i = 0; i < resp_bytes.size() && i < resp_len(op); i++) begin
            value_check($sformatf("response byte %0d", i), 32'(resp_bytes[i]),
                        32'(resp_byte(op, status, i)));
        end
        pushes.delete();
        rows.delete();
        resp_bytes.delete();
        starts = 0;
        events = 0;
    endtask

    // Sample mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (rst) begin
            dec_busy     = 1'b0;
            ready_expect = 1'b0;
            value_check("pulse outputs, weights_ready and uart_tx in reset",
                        32'({mlp_ctrl.push_col0, mlp_ctrl.push_col1, mlp_ctrl.act_valid,
                             mlp_ctrl.start, weights_ready, uart_tx}), 32'h1);
        end else begin
            if (mlp_ctrl.push_col0 || mlp_ctrl.push_col1) begin
                pushes.push_back({mlp_ctrl.push_col1, mlp_ctrl.push_col0, mlp_ctrl.wf_data});
                events++;
                // Rises with the last push of a weight write and stays high
                if (op == CMD_WRITE_WEIGHT && pushes.size() == 4) begin
                    ready_expect = 1'b1;
                end
            end
            if (mlp_ctrl.act_valid) begin
                rows.push_back(mlp_ctrl.act_data);
                events++;
            end
            if (mlp_ctrl.start) begin
                starts++;
                events++;
            end
            value_check("weights_ready", 32'(weights_ready), 32'(ready_expect));

            // Serial decoder counts from the first low sample of the start bit
            if (!dec_busy) begin
                dec_busy = !uart_tx;
                dec_cnt  = 0;
            end else begin
                dec_cnt++;
                if (dec_cnt == 9 * CLKS_PER_BIT + CLKS_PER_BIT / 2) begin
                    if (!uart_tx) begin
                        event_errs++;
                        $display("Stop bit of a response byte was low at %0t", $time);
                    end
                    resp_bytes.push_back(dec_byte);
                    events++;
                    dec_busy = 1'b0;
                end else if (dec_cnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                    dec_byte = {uart_tx, dec_byte[7:1]};
                end
            end

            if (check) begin
                compare_command();
            end
        end
    end

endmodule

// File: verif/tb_uart_controller.sv
`timescale 1ns/1ps

module tb_uart_controller
    import mlp_cmd_pkg::*;
();

    localparam int CLOCK_FREQ   = 10_000_000;
    localparam int BAUD_RATE    = 1_000_000;
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
    localparam int DRIVE_DELAY  = 10;
    localparam int WAIT_LIMIT   = 80 * CLKS_PER_BIT;
    localparam int QUIET_CYCLES = 3 * CLKS_PER_BIT;

    logic        clk;
    logic        rst;
    logic        rx_line;
    logic        tx_line;
    mlp_ctrl_t   mlp_ctrl;
    logic        weights_ready;
    mlp_status_t status;
    byte_t       cmd_op;
    byte_t [3:0] cmd_payload;
    logic        check;
    int          events;
    int          expect_n;
    int          value_errs;
    int          event_errs;
    int          timeouts;
    logic [15:0] lfsr;

    always #50 clk = ~clk;

    uart_controller #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) dut (
        .clk(clk), .rst(rst), .uart_rx(rx_line), .uart_tx(tx_line), .mlp_ctrl(mlp_ctrl),
        .weights_ready(weights_ready), .status(status)
    );

    uart_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_checker (
        .clk(clk), .rst(rst), .uart_tx(tx_line), .mlp_ctrl(mlp_ctrl),
        .weights_ready(weights_ready), .status(status), .op(cmd_op), .payload(cmd_payload),
        .check(check), .events(events), .expect_n(expect_n), .value_errs(value_errs),
        .event_errs(event_errs)
    );

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Start bit, eight data bits LSB first, stop bit
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            rx_line = frame[4'(i)];
            repeat (CLKS_PER_BIT) @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic run_command(input byte_t op);
        logic [31:0] r;
        int          i;
        int          t;
        cmd_op = op;
        take_bits(4, r);
        status.state = r[3:0];
        take_bits(5, r);
        status.cycle_cnt = r[4:0];
        take_bits(32, r);
        status.acc0 = r;
        send_byte(op);
        if (op == CMD_WRITE_WEIGHT || op == CMD_WRITE_ACT) begin
            take_bits(32, r);
            cmd_payload = r;
            for (i = 0; i < 4; i++) begin
                send_byte(cmd_payload[2'(i)]);
            end
        end
        t = 0;
        while (events != expect_n && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (events != expect_n) begin
            timeouts++;
            $display("Timed out on command 0x%02h after %0d of %0d expected events",
                     op, events, expect_n);
        end
        // Quiet time so that late or extra events are counted
        t = 0;
        while (t < QUIET_CYCLES) begin
            @(posedge clk);
            t++;
        end
        #DRIVE_DELAY;
        check = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        check = 1'b0;
    endtask

    initial begin
        int round;
        clk         = 1'b0;
        rst         = 1'b1;
        rx_line     = 1'b1;
        check       = 1'b0;
        status      = '0;
        cmd_op      = '0;
        cmd_payload = '0;
        timeouts    = 0;
        lfsr        = 16'd38;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        for (round = 0; round < 2; round++) begin
            run_command(CMD_WRITE_WEIGHT);
            run_command(CMD_WRITE_ACT);
            run_command(CMD_EXECUTE);
            run_command(CMD_READ_RESULT);
            run_command(CMD_STATUS);
            // Unknown code, STATUS must still answer after it
            run_command(8'hA6);
            run_command(CMD_STATUS);
        end
        $display("Errors: %0d value, %0d event, %0d timeout", value_errs, event_errs, timeouts);
        if (value_errs + event_errs + timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
src/mlp_cmd_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_parser.sv
src/mlp_loader.sv
src/resp_sender.sv
src/uart_controller.sv
verif/uart_checker.sv
verif/tb_uart_controller.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_uart_controller \
    -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
